// ==== wb_bus_pkg.sv ====
package wb_bus_pkg;

    // Wishbone bus widths seen by the user area
    localparam int WB_DATA_WIDTH = 32;
    localparam int WB_ADDR_WIDTH = 32;
    localparam int WB_SEL_WIDTH  = WB_DATA_WIDTH / 8;

    // Base of the counter page in the user address space
    localparam logic [WB_ADDR_WIDTH-1:0] CTR_BASE_ADDR = 32'h3000_0000;

    // Register offsets inside the page
    // Read gives the live count, write loads the selected bytes
    localparam logic [7:0] REG_COUNT_OFS   = 8'h00;

    // Enable and interrupt enable
    localparam logic [7:0] REG_CTRL_OFS    = 8'h04;

    // Value the count is matched against
    localparam logic [7:0] REG_COMPARE_OFS = 8'h08;

    // Sticky match flag, write 1 to clear
    localparam logic [7:0] REG_STATUS_OFS  = 8'h0C;

endpackage

// ==== counter_pkg.sv ====
package counter_pkg;

    // Bit positions in CTRL
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_IRQ_EN_BIT = 1;

    // Bit positions in STATUS
    localparam int STATUS_MATCH_BIT = 0;

    // Logic analyzer bus layout
    // Width of every LA bus from the management side
    localparam int LA_WIDTH = 128;

    // First probe of the force-load field
    // The field is COUNT_WIDTH probes wide
    localparam int LA_LOAD_LSB = 32;

    // User GPIO pads driven with the count
    localparam int IO_PAD_WIDTH = 16;

endpackage

// ==== wb_slave_adapter.sv ====
`timescale 1ns/1ps

module wb_slave_adapter (
    input  logic                                clk,
    input  logic                                reset,
    // Wishbone slave side
    input  logic                                wbs_cyc_i,
    input  logic                                wbs_stb_i,
    input  logic                                wbs_we_i,
    input  logic [wb_bus_pkg::WB_SEL_WIDTH-1:0]  wbs_sel_i,
    input  logic [wb_bus_pkg::WB_ADDR_WIDTH-1:0] wbs_adr_i,
    input  logic [wb_bus_pkg::WB_DATA_WIDTH-1:0] wbs_dat_i,
    output logic                                wbs_ack_o,
    output logic [wb_bus_pkg::WB_DATA_WIDTH-1:0] wbs_dat_o,
    // Request link to the register block
    output logic                                req_valid_o,
    output logic                                req_write_o,
    output logic [wb_bus_pkg::WB_ADDR_WIDTH-1:0] req_addr_o,
    output logic [wb_bus_pkg::WB_DATA_WIDTH-1:0] req_wdata_o,
    output logic [wb_bus_pkg::WB_SEL_WIDTH-1:0]  req_strb_o,
    input  logic                                req_ready_i,
    // Response link from the register block
    input  logic                                resp_valid_i,
    input  logic [wb_bus_pkg::WB_DATA_WIDTH-1:0] resp_rdata_i
);
    import wb_bus_pkg::*;

    logic bus_active;
    logic accepted_q;

    // A cycle is live while both cyc and stb are held
    assign bus_active = wbs_cyc_i && wbs_stb_i;

    // Set once the current strobe has been taken
    // Cleared as soon as the master drops stb
    always_ff @(posedge clk) begin
        if (reset) begin
            accepted_q <= 1'b0;
        end else if (!bus_active) begin
            accepted_q <= 1'b0;
        end else if (req_valid_o && req_ready_i) begin
            accepted_q <= 1'b1;
        end
    end

    // One request per strobe
    assign req_valid_o = bus_active && !accepted_q;
    assign req_write_o = wbs_we_i;
    assign req_addr_o  = wbs_adr_i;
    assign req_wdata_o = wbs_dat_i;

    // Byte strobes only count on writes
    assign req_strb_o  = wbs_sel_i & {WB_SEL_WIDTH{wbs_we_i}};

    // Response goes straight out as the ack cycle
    assign wbs_ack_o = resp_valid_i;
    // Keep the data bus quiet outside the ack cycle
    assign wbs_dat_o = resp_valid_i ? resp_rdata_i : '0;

endmodule

// ==== counter_regs.sv ====
`timescale 1ns/1ps

module counter_regs #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                                clk,
    input  logic                                reset,
    // Request link from the bus adapter
    input  logic                                req_valid_i,
    input  logic                                req_write_i,
    input  logic [wb_bus_pkg::WB_ADDR_WIDTH-1:0] req_addr_i,
    input  logic [wb_bus_pkg::WB_DATA_WIDTH-1:0] req_wdata_i,
    input  logic [wb_bus_pkg::WB_SEL_WIDTH-1:0]  req_strb_i,
    output logic                                req_ready_o,
    // Response link back to the adapter
    output logic                                resp_valid_o,
    output logic [wb_bus_pkg::WB_DATA_WIDTH-1:0] resp_rdata_o,
    // Live count from the core
    input  logic [COUNT_WIDTH-1:0]              count_i,
    // Bus load of the count
    output logic                                cnt_wr_en_o,
    output logic [COUNT_WIDTH/8-1:0]            cnt_wr_strb_o,
    output logic [COUNT_WIDTH-1:0]              cnt_wr_data_o,
    // Control and status
    output logic                                enable_o,
    output logic                                match_o,
    output logic                                irq_o
);
    import wb_bus_pkg::*;
    import counter_pkg::*;

    localparam int NUM_BYTES = COUNT_WIDTH / 8;
    // Offset field is as wide as the offset constants
    localparam int OFS_WIDTH = $bits(REG_COUNT_OFS);

    logic                     accept;
    logic                     in_page;
    logic [OFS_WIDTH-1:0]     ofs;
    logic                     wr_count;
    logic                     wr_ctrl;
    logic                     wr_compare;
    logic                     wr_status;
    logic [WB_DATA_WIDTH-1:0] rdata_next;
    logic                     irq_en_q;
    logic [COUNT_WIDTH-1:0]   compare_q;

    // Stall new requests while the response is out
    assign req_ready_o = !resp_valid_o;
    assign accept      = req_valid_i && req_ready_o;

    // Page match against the base, low bits select the register
    assign in_page = req_addr_i[WB_ADDR_WIDTH-1:OFS_WIDTH] ==
                     CTR_BASE_ADDR[WB_ADDR_WIDTH-1:OFS_WIDTH];
    assign ofs     = req_addr_i[OFS_WIDTH-1:0];

    assign wr_count   = accept && req_write_i && in_page && (ofs == REG_COUNT_OFS);
    assign wr_ctrl    = accept && req_write_i && in_page && (ofs == REG_CTRL_OFS);
    assign wr_compare = accept && req_write_i && in_page && (ofs == REG_COMPARE_OFS);
    assign wr_status  = accept && req_write_i && in_page && (ofs == REG_STATUS_OFS);

    // Read-back mux, unmapped offsets read zero
    always_comb begin
        rdata_next = '0;
        if (in_page) begin
            case (ofs)
                REG_COUNT_OFS:   rdata_next[COUNT_WIDTH-1:0] = count_i;
                REG_CTRL_OFS: begin
                    rdata_next[CTRL_ENABLE_BIT] = enable_o;
                    rdata_next[CTRL_IRQ_EN_BIT] = irq_en_q;
                end
                REG_COMPARE_OFS: rdata_next[COUNT_WIDTH-1:0] = compare_q;
                REG_STATUS_OFS:  rdata_next[STATUS_MATCH_BIT] = match_o;
                default:         rdata_next = '0;
            endcase
        end
    end

    // Response pulse and captured read data
    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid_o <= 1'b0;
        end else begin
            resp_valid_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp_rdata_o <= rdata_next;
        end
    end

    // COUNT load is handed to the core one cycle after accept
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt_wr_en_o <= 1'b0;
        end else begin
            cnt_wr_en_o <= wr_count;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_count) begin
            cnt_wr_strb_o <= req_strb_i[NUM_BYTES-1:0];
            cnt_wr_data_o <= req_wdata_i[COUNT_WIDTH-1:0];
        end
    end

    // CTRL and COMPARE
    always_ff @(posedge clk) begin
        if (reset) begin
            enable_o  <= 1'b0;
            irq_en_q  <= 1'b0;
            compare_q <= '0;
        end else begin
            if (wr_ctrl && req_strb_i[0]) begin
                enable_o <= req_wdata_i[CTRL_ENABLE_BIT];
                irq_en_q <= req_wdata_i[CTRL_IRQ_EN_BIT];
            end
            if (wr_compare) begin
                for (int b = 0; b < NUM_BYTES; b++) begin
                    if (req_strb_i[b]) begin
                        compare_q[b*8 +: 8] <= req_wdata_i[b*8 +: 8];
                    end
                end
            end
        end
    end

    // Sticky match flag, a new match beats a clear in the same cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            match_o <= 1'b0;
        end else if (enable_o && (count_i == compare_q)) begin
            match_o <= 1'b1;
        end else if (wr_status && req_strb_i[0] && req_wdata_i[STATUS_MATCH_BIT]) begin
            match_o <= 1'b0;
        end
    end

    // Interrupt line registered from flag and enable
    always_ff @(posedge clk) begin
        if (reset) begin
            irq_o <= 1'b0;
        end else begin
            irq_o <= match_o && irq_en_q;
        end
    end

endmodule

// ==== count_core.sv ====
`timescale 1ns/1ps

module count_core #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                     clk,
    input  logic                     reset,
    // Increment enable from CTRL
    input  logic                     enable_i,
    // Bus load, one strobe per byte
    input  logic                     wr_en_i,
    input  logic [COUNT_WIDTH/8-1:0] wr_strb_i,
    input  logic [COUNT_WIDTH-1:0]   wr_data_i,
    // LA force-load
    input  logic [COUNT_WIDTH-1:0]   la_mask_i,
    input  logic [COUNT_WIDTH-1:0]   la_value_i,
    output logic [COUNT_WIDTH-1:0]   count_o
);

    localparam int NUM_BYTES = COUNT_WIDTH / 8;

    logic [COUNT_WIDTH-1:0] wr_merged;
    logic                   la_load;

    // Selected bytes from the bus, the rest kept
    always_comb begin
        wr_merged = count_o;
        for (int b = 0; b < NUM_BYTES; b++) begin
            if (wr_strb_i[b]) begin
                wr_merged[b*8 +: 8] = wr_data_i[b*8 +: 8];
            end
        end
    end

    // Any forced probe turns the LA load on
    assign la_load = |la_mask_i;

    // Bus write, then LA load, then increment
    always_ff @(posedge clk) begin
        if (reset) begin
            count_o <= '0;
        end else if (wr_en_i) begin
            count_o <= wr_merged;
        end else if (la_load) begin
            // Probes that are not forced load as zero
            count_o <= la_mask_i & la_value_i;
        end else if (enable_i) begin
            // Wraps naturally at the top
            count_o <= count_o + 1'b1;
        end
    end

endmodule

// ==== la_probe_mux.sv ====
`timescale 1ns/1ps

module la_probe_mux #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                            clk,
    input  logic                            reset,
    // LA buses from the management side
    input  logic [counter_pkg::LA_WIDTH-1:0] la_data_in_i,
    input  logic [counter_pkg::LA_WIDTH-1:0] la_oenb_i,
    output logic [counter_pkg::LA_WIDTH-1:0] la_data_out_o,
    // Observed state
    input  logic [COUNT_WIDTH-1:0]          count_i,
    input  logic                            match_i,
    // Force-load to the core
    output logic [COUNT_WIDTH-1:0]          la_mask_o,
    output logic [COUNT_WIDTH-1:0]          la_value_o
);
    import counter_pkg::*;

    // A probe forces its bit when its oenb is low
    always_ff @(posedge clk) begin
        if (reset) begin
            la_mask_o <= '0;
        end else begin
            la_mask_o <= ~la_oenb_i[LA_LOAD_LSB +: COUNT_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        la_value_o <= la_data_in_i[LA_LOAD_LSB +: COUNT_WIDTH];
    end

    // Count in the low bits, match right above it
    assign la_data_out_o = {{(LA_WIDTH-COUNT_WIDTH-1){1'b0}}, match_i, count_i};

endmodule

// ==== user_counter_top.sv ====
`timescale 1ns/1ps

module user_counter_top #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                                clk,
    input  logic                                reset,
    // Wishbone slave
    input  logic                                wbs_cyc_i,
    input  logic                                wbs_stb_i,
    input  logic                                wbs_we_i,
    input  logic [wb_bus_pkg::WB_SEL_WIDTH-1:0]  wbs_sel_i,
    input  logic [wb_bus_pkg::WB_ADDR_WIDTH-1:0] wbs_adr_i,
    input  logic [wb_bus_pkg::WB_DATA_WIDTH-1:0] wbs_dat_i,
    output logic                                wbs_ack_o,
    output logic [wb_bus_pkg::WB_DATA_WIDTH-1:0] wbs_dat_o,
    // Logic analyzer
    input  logic [counter_pkg::LA_WIDTH-1:0]     la_data_in_i,
    input  logic [counter_pkg::LA_WIDTH-1:0]     la_oenb_i,
    output logic [counter_pkg::LA_WIDTH-1:0]     la_data_out_o,
    // GPIO pads
    output logic [counter_pkg::IO_PAD_WIDTH-1:0] io_out_o,
    output logic [counter_pkg::IO_PAD_WIDTH-1:0] io_oeb_o,
    // Interrupts, only line 0 has a source
    output logic [2:0]                          irq_o
);
    import wb_bus_pkg::*;
    import counter_pkg::*;

    logic                     req_valid;
    logic                     req_write;
    logic [WB_ADDR_WIDTH-1:0] req_addr;
    logic [WB_DATA_WIDTH-1:0] req_wdata;
    logic [WB_SEL_WIDTH-1:0]  req_strb;
    logic                     req_ready;
    logic                     resp_valid;
    logic [WB_DATA_WIDTH-1:0] resp_rdata;

    logic                     cnt_wr_en;
    logic [COUNT_WIDTH/8-1:0] cnt_wr_strb;
    logic [COUNT_WIDTH-1:0]   cnt_wr_data;
    logic [COUNT_WIDTH-1:0]   la_mask;
    logic [COUNT_WIDTH-1:0]   la_value;
    logic [COUNT_WIDTH-1:0]   count;
    logic                     enable;
    logic                     match;
    logic                     irq_match;

    // Count padded so the pad slice exists for any width
    logic [IO_PAD_WIDTH+COUNT_WIDTH-1:0] count_ext;

    wb_slave_adapter u_adapter (
        .clk          (clk),
        .reset        (reset),
        .wbs_cyc_i    (wbs_cyc_i),
        .wbs_stb_i    (wbs_stb_i),
        .wbs_we_i     (wbs_we_i),
        .wbs_sel_i    (wbs_sel_i),
        .wbs_adr_i    (wbs_adr_i),
        .wbs_dat_i    (wbs_dat_i),
        .wbs_ack_o    (wbs_ack_o),
        .wbs_dat_o    (wbs_dat_o),
        .req_valid_o  (req_valid),
        .req_write_o  (req_write),
        .req_addr_o   (req_addr),
        .req_wdata_o  (req_wdata),
        .req_strb_o   (req_strb),
        .req_ready_i  (req_ready),
        .resp_valid_i (resp_valid),
        .resp_rdata_i (resp_rdata)
    );

    counter_regs #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_regs (
        .clk           (clk),
        .reset         (reset),
        .req_valid_i   (req_valid),
        .req_write_i   (req_write),
        .req_addr_i    (req_addr),
        .req_wdata_i   (req_wdata),
        .req_strb_i    (req_strb),
        .req_ready_o   (req_ready),
        .resp_valid_o  (resp_valid),
        .resp_rdata_o  (resp_rdata),
        .count_i       (count),
        .cnt_wr_en_o   (cnt_wr_en),
        .cnt_wr_strb_o (cnt_wr_strb),
        .cnt_wr_data_o (cnt_wr_data),
        .enable_o      (enable),
        .match_o       (match),
        .irq_o         (irq_match)
    );

    count_core #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_core (
        .clk        (clk),
        .reset      (reset),
        .enable_i   (enable),
        .wr_en_i    (cnt_wr_en),
        .wr_strb_i  (cnt_wr_strb),
        .wr_data_i  (cnt_wr_data),
        .la_mask_i  (la_mask),
        .la_value_i (la_value),
        .count_o    (count)
    );

    la_probe_mux #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_la (
        .clk           (clk),
        .reset         (reset),
        .la_data_in_i  (la_data_in_i),
        .la_oenb_i     (la_oenb_i),
        .la_data_out_o (la_data_out_o),
        .count_i       (count),
        .match_i       (match),
        .la_mask_o     (la_mask),
        .la_value_o    (la_value)
    );

    assign count_ext = {{IO_PAD_WIDTH{1'b0}}, count};

    // Pad stage, low count bits out and drivers on after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            io_out_o <= '0;
            io_oeb_o <= '1;
        end else begin
            io_out_o <= count_ext[IO_PAD_WIDTH-1:0];
            io_oeb_o <= '0;
        end
    end

    // Lines 1 and 2 have no source
    assign irq_o = {2'b00, irq_match};

endmodule

// ==== tb_user_counter.sv ====
`timescale 1ns/1ps

module tb_user_counter;
    import wb_bus_pkg::*;
    import counter_pkg::*;

    localparam int COUNT_WIDTH  = 16;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_TESTS    = 6;
    // Per-test cycle budget sized by the match wait in test 5
    localparam int TEST_BUDGET    = 332;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_TESTS * TEST_BUDGET;

    // Register values built from the bit positions
    localparam logic [WB_DATA_WIDTH-1:0] CTRL_ENABLE  = WB_DATA_WIDTH'(1) << CTRL_ENABLE_BIT;
    localparam logic [WB_DATA_WIDTH-1:0] CTRL_IRQ_EN  = WB_DATA_WIDTH'(1) << CTRL_IRQ_EN_BIT;
    localparam logic [WB_DATA_WIDTH-1:0] STATUS_MATCH = WB_DATA_WIDTH'(1) << STATUS_MATCH_BIT;

    logic                     clk;
    logic                     reset;
    logic                     wbs_cyc_i;
    logic                     wbs_stb_i;
    logic                     wbs_we_i;
    logic [WB_SEL_WIDTH-1:0]  wbs_sel_i;
    logic [WB_ADDR_WIDTH-1:0] wbs_adr_i;
    logic [WB_DATA_WIDTH-1:0] wbs_dat_i;
    logic                     wbs_ack_o;
    logic [WB_DATA_WIDTH-1:0] wbs_dat_o;
    logic [LA_WIDTH-1:0]      la_data_in_i;
    logic [LA_WIDTH-1:0]      la_oenb_i;
    logic [LA_WIDTH-1:0]      la_data_out_o;
    logic [IO_PAD_WIDTH-1:0]  io_out_o;
    logic [IO_PAD_WIDTH-1:0]  io_oeb_o;
    logic [2:0]               irq_o;

    int          cycle_count;
    int          error_count;
    int          check_total;
    int          tests_done;
    int          test_errors_start;
    logic [31:0] rng_state;

    user_counter_top #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) DUT (
        .clk           (clk),
        .reset         (reset),
        .wbs_cyc_i     (wbs_cyc_i),
        .wbs_stb_i     (wbs_stb_i),
        .wbs_we_i      (wbs_we_i),
        .wbs_sel_i     (wbs_sel_i),
        .wbs_adr_i     (wbs_adr_i),
        .wbs_dat_i     (wbs_dat_i),
        .wbs_ack_o     (wbs_ack_o),
        .wbs_dat_o     (wbs_dat_o),
        .la_data_in_i  (la_data_in_i),
        .la_oenb_i     (la_oenb_i),
        .la_data_out_o (la_data_out_o),
        .io_out_o      (io_out_o),
        .io_oeb_o      (io_oeb_o),
        .irq_o         (irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Watchdog that also counts the edges used as accept references
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks failed");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    // Register address inside the counter page
    function automatic logic [WB_ADDR_WIDTH-1:0] reg_addr(input logic [7:0] ofs);
        return {CTR_BASE_ADDR[WB_ADDR_WIDTH-1:8], ofs};
    endfunction

    task automatic check_data(input string name, input logic [WB_DATA_WIDTH-1:0] actual,
                              input logic [WB_DATA_WIDTH-1:0] expected);
        check_total++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_count(input string name, input logic [COUNT_WIDTH-1:0] actual,
                               input logic [COUNT_WIDTH-1:0] expected);
        check_total++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_pads(input string name, input logic [IO_PAD_WIDTH-1:0] actual,
                              input logic [IO_PAD_WIDTH-1:0] expected);
        check_total++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        check_total++;
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
        end
    endtask

    // One Wishbone cycle held until ack
    // Ack is sampled mid-cycle
    task automatic wb_transfer(input logic we, input logic [WB_ADDR_WIDTH-1:0] adr,
                               input logic [WB_DATA_WIDTH-1:0] dat,
                               input logic [WB_SEL_WIDTH-1:0] sel,
                               output logic [WB_DATA_WIDTH-1:0] rdata, output int accept_cycle);
        @(posedge clk);
        wbs_cyc_i <= 1'b1;
        wbs_stb_i <= 1'b1;
        wbs_we_i  <= we;
        wbs_adr_i <= adr;
        wbs_dat_i <= dat;
        wbs_sel_i <= sel;
        @(negedge clk);
        while (!wbs_ack_o) begin
            @(negedge clk);
        end
        rdata = wbs_dat_o;
        // The accept edge is the one right before ack
        accept_cycle = cycle_count;
        @(posedge clk);
        wbs_cyc_i <= 1'b0;
        wbs_stb_i <= 1'b0;
        wbs_we_i  <= 1'b0;
    endtask

    task automatic wb_write(input logic [WB_ADDR_WIDTH-1:0] adr,
                            input logic [WB_DATA_WIDTH-1:0] dat,
                            input logic [WB_SEL_WIDTH-1:0] sel);
        logic [WB_DATA_WIDTH-1:0] unused_rdata;
        int                       unused_cycle;
        wb_transfer(1'b1, adr, dat, sel, unused_rdata, unused_cycle);
    endtask

    task automatic wb_read(input logic [WB_ADDR_WIDTH-1:0] adr,
                           output logic [WB_DATA_WIDTH-1:0] rdata, output int accept_cycle);
        wb_transfer(1'b0, adr, '0, '1, rdata, accept_cycle);
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        if (error_count == test_errors_start) begin
            $display("Test %0d %s: ok", tests_done, name);
        end else begin
            $display("Test %0d %s: %0d errors", tests_done, name, error_count - test_errors_start);
        end
        test_errors_start = error_count;
    endtask

    task automatic verify_reset_state();
        logic [WB_DATA_WIDTH-1:0] rd;
        int                       acc;
        @(negedge clk);
        check_pads("io_oeb_o", io_oeb_o, '0);
        check_bit("wbs_ack_o", wbs_ack_o, 1'b0);
        check_data("irq_o", WB_DATA_WIDTH'(irq_o), '0);
        wb_read(reg_addr(REG_COUNT_OFS), rd, acc);
        check_data("COUNT after reset", rd, '0);
        wb_read(reg_addr(REG_CTRL_OFS), rd, acc);
        check_data("CTRL after reset", rd, '0);
        // Stopped counter must hold
        repeat (5) @(posedge clk);
        wb_read(reg_addr(REG_COUNT_OFS), rd, acc);
        check_data("COUNT while stopped", rd, '0);
    endtask

    task automatic measure_free_counting();
        logic [WB_DATA_WIDTH-1:0] rd1;
        logic [WB_DATA_WIDTH-1:0] rd2;
        logic [IO_PAD_WIDTH-1:0]  pad1;
        int                       acc1;
        int                       acc2;
        wb_write(reg_addr(REG_CTRL_OFS), CTRL_ENABLE, '1);
        wb_read(reg_addr(REG_COUNT_OFS), rd1, acc1);
        repeat (3) @(posedge clk);
        wb_read(reg_addr(REG_COUNT_OFS), rd2, acc2);
        // One step per edge between the two accepts
        check_count("COUNT advance", rd2[COUNT_WIDTH-1:0] - rd1[COUNT_WIDTH-1:0],
                    COUNT_WIDTH'(acc2 - acc1));
        @(negedge clk);
        pad1 = io_out_o;
        @(negedge clk);
        check_pads("io_out_o step", io_out_o, pad1 + IO_PAD_WIDTH'(1));
        wb_write(reg_addr(REG_CTRL_OFS), '0, '1);
    endtask

    task automatic load_count_bytes();
        logic [COUNT_WIDTH-1:0]   model;
        logic [WB_DATA_WIDTH-1:0] rd;
        logic [WB_DATA_WIDTH-1:0] val;
        int                       acc;
        wb_read(reg_addr(REG_COUNT_OFS), rd, acc);
        model = rd[COUNT_WIDTH-1:0];
        // One byte at a time while the others stay
        for (int b = 0; b < COUNT_WIDTH / 8; b++) begin
            next_random(val);
            wb_write(reg_addr(REG_COUNT_OFS), val, WB_SEL_WIDTH'(1 << b));
            model[b*8 +: 8] = val[b*8 +: 8];
            wb_read(reg_addr(REG_COUNT_OFS), rd, acc);
            check_count("COUNT after byte load", rd[COUNT_WIDTH-1:0], model);
        end
        next_random(val);
        wb_write(reg_addr(REG_COUNT_OFS), val, WB_SEL_WIDTH'((1 << (COUNT_WIDTH / 8)) - 1));
        model = val[COUNT_WIDTH-1:0];
        wb_read(reg_addr(REG_COUNT_OFS), rd, acc);
        check_count("COUNT after full load", rd[COUNT_WIDTH-1:0], model);
    endtask

    task automatic force_la_load();
        logic [31:0]            r;
        logic [COUNT_WIDTH-1:0] mask;
        logic [COUNT_WIDTH-1:0] value;
        logic [COUNT_WIDTH-1:0] expected;
        next_random(r);
        mask = r[COUNT_WIDTH-1:0];
        if (mask == '0) begin
            mask = COUNT_WIDTH'(1);
        end
        next_random(r);
        value    = r[COUNT_WIDTH-1:0];
        expected = mask & value;
        @(posedge clk);
        la_oenb_i[LA_LOAD_LSB +: COUNT_WIDTH]    <= ~mask;
        la_data_in_i[LA_LOAD_LSB +: COUNT_WIDTH] <= value;
        // Input register then core
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_count("la_data_out_o count", la_data_out_o[COUNT_WIDTH-1:0], expected);
        // Pad register is one more stage
        @(negedge clk);
        check_pads("io_out_o after LA load", io_out_o, expected[IO_PAD_WIDTH-1:0]);
        @(posedge clk);
        la_oenb_i    <= '1;
        la_data_in_i <= '0;
        repeat (2) @(posedge clk);
    endtask

    task automatic trigger_match_irq();
        logic [31:0]              r;
        logic [COUNT_WIDTH-1:0]   compare;
        logic [COUNT_WIDTH-1:0]   start;
        logic [WB_DATA_WIDTH-1:0] rd;
        logic                     irq_seen;
        int                       offset;
        int                       waited;
        int                       acc;
        next_random(r);
        // Kept above the largest offset so the start stays below it
        compare = r[COUNT_WIDTH-1:0] | COUNT_WIDTH'(128);
        next_random(r);
        offset = 8 + int'(r[5:0]);
        start  = compare - COUNT_WIDTH'(offset);
        // Free counting from zero against a zero COMPARE left the flag set
        wb_write(reg_addr(REG_STATUS_OFS), STATUS_MATCH, '1);
        wb_write(reg_addr(REG_COMPARE_OFS), WB_DATA_WIDTH'(compare), '1);
        wb_write(reg_addr(REG_COUNT_OFS), WB_DATA_WIDTH'(start), '1);
        wb_write(reg_addr(REG_CTRL_OFS), CTRL_ENABLE | CTRL_IRQ_EN, '1);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!irq_o[0] && waited < offset + 8);
        check_bit("irq_o[0] after match", irq_o[0], 1'b1);
        check_bit("la_data_out_o match", la_data_out_o[COUNT_WIDTH], 1'b1);
        wb_read(reg_addr(REG_STATUS_OFS), rd, acc);
        check_data("STATUS after match", rd, STATUS_MATCH);
        wb_write(reg_addr(REG_STATUS_OFS), STATUS_MATCH, '1);
        wb_read(reg_addr(REG_STATUS_OFS), rd, acc);
        check_data("STATUS after clear", rd, '0);
        @(negedge clk);
        check_bit("irq_o[0] after clear", irq_o[0], 1'b0);
        check_bit("la_data_out_o match after clear", la_data_out_o[COUNT_WIDTH], 1'b0);
        // Second match with the interrupt masked
        wb_write(reg_addr(REG_CTRL_OFS), CTRL_ENABLE, '1);
        wb_write(reg_addr(REG_COUNT_OFS), WB_DATA_WIDTH'(compare - COUNT_WIDTH'(4)), '1);
        irq_seen = 1'b0;
        repeat (16) begin
            @(negedge clk);
            irq_seen = irq_seen | irq_o[0];
        end
        check_bit("irq_o[0] with interrupt disabled", irq_seen, 1'b0);
        wb_read(reg_addr(REG_STATUS_OFS), rd, acc);
        check_data("STATUS with interrupt disabled", rd, STATUS_MATCH);
        wb_write(reg_addr(REG_CTRL_OFS), '0, '1);
        wb_write(reg_addr(REG_STATUS_OFS), STATUS_MATCH, '1);
    endtask

    task automatic race_bus_and_la();
        logic [31:0]              r;
        logic [COUNT_WIDTH-1:0]   bus_value;
        logic [WB_DATA_WIDTH-1:0] rd;
        int                       acc;
        next_random(r);
        bus_value = r[COUNT_WIDTH-1:0] | COUNT_WIDTH'(1);
        @(posedge clk);
        la_oenb_i[LA_LOAD_LSB +: COUNT_WIDTH]    <= '0;
        la_data_in_i[LA_LOAD_LSB +: COUNT_WIDTH] <= ~bus_value;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_count("count under LA load", la_data_out_o[COUNT_WIDTH-1:0], ~bus_value);
        // LA released on the accept edge
        // The mask is still set when the core takes the write
        fork
            wb_write(reg_addr(REG_COUNT_OFS), WB_DATA_WIDTH'(bus_value), '1);
            begin
                repeat (2) @(posedge clk);
                la_oenb_i    <= '1;
                la_data_in_i <= '0;
            end
        join
        wb_read(reg_addr(REG_COUNT_OFS), rd, acc);
        check_count("COUNT after write during LA load", rd[COUNT_WIDTH-1:0], bus_value);
        wb_read(reg_addr(8'h10), rd, acc);
        check_data("unmapped offset", rd, '0);
        // Offset 0 of another page must not alias COUNT
        wb_read(CTR_BASE_ADDR ^ 32'h0001_0000, rd, acc);
        check_data("address outside the page", rd, '0);
    endtask

    initial begin
        rng_state         = 32'h3092_3d04;
        error_count       = 0;
        check_total       = 0;
        tests_done        = 0;
        test_errors_start = 0;
        reset        <= 1'b1;
        wbs_cyc_i    <= 1'b0;
        wbs_stb_i    <= 1'b0;
        wbs_we_i     <= 1'b0;
        wbs_sel_i    <= '0;
        wbs_adr_i    <= '0;
        wbs_dat_i    <= '0;
        la_data_in_i <= '0;
        la_oenb_i    <= '1;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_pads("io_oeb_o in reset", io_oeb_o, '1);
        @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);

        verify_reset_state();
        finish_test("reset state");
        measure_free_counting();
        finish_test("free counting");
        load_count_bytes();
        finish_test("byte loads");
        force_la_load();
        finish_test("LA load");
        trigger_match_irq();
        finish_test("match and interrupt");
        race_bus_and_la();
        finish_test("write priority and decode");

        $display("Tests %0d, checks %0d, errors %0d", tests_done, check_total, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== user_counter_top.f ====
wb_bus_pkg.sv
counter_pkg.sv
wb_slave_adapter.sv
counter_regs.sv
count_core.sv
la_probe_mux.sv
user_counter_top.sv
tb_user_counter.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the counter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module tb_user_counter \
    -f user_counter_top.f \
    --Mdir obj_dir -o sim_user_counter > build.log 2>&1 \
    || { cat build.log; exit 1; }

./obj_dir/sim_user_counter > sim.log 2>&1
cat sim.log

# Pass only when the pass message reached the log
grep -q "All checks passed" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
